// ==== sim/fir_golden.txt ====
# columns: sampleBit valid reset expectedOut ("-" where no output is checked)
# a line starting with @ names the test that follows
@fill_and_zeros
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -
0 1 0 -24212
@moving_one
1 1 0 -4492
0 1 0 -17972
0 1 0 -26976
0 1 0 -22540
0 1 0 -25334
0 1 0 -23432
@alternating
1 1 0 -
0 1 0 -
1 1 0 -
0 1 0 -
1 1 0 -
0 1 0 -
@random_gaps
1 1 0 -
0 0 0 -
1 1 0 -
1 1 0 -
0 1 0 -
0 0 0 -
1 1 0 -
0 1 0 -
0 1 0 -
1 1 0 -
@reset_refill
0 0 1 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 -
1 1 0 24212

// ==== verilog.f ====
logic/firPkg.sv
logic/sampleWindow.sv
logic/coefLut.sv
logic/adderTree.sv
logic/firTop.sv
sim/firTop_props.sv
sim/firTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= firTb
FILELIST  ?= verilog.f
LOG       ?= sim.log
FAIL_MSG  := *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/firTb.sv ====
`timescale 1ns/1ps

module firTb;
    import firPkg::*;

    localparam int drainLimit = 50;

    logic clkDS;
    logic rst;
    logic sampleBit;
    logic sampleValid;
    sumType filterOut;
    logic outValid;

    // Reference window, position 0 is the newest sample
    windowType modelWin;
    int modelFill;
    sumType expQ[$];

    integer seed;
    int fd;
    int errors;
    int testErrors;
    int testCount;
    int failedTests;
    string testName;

    firTop i_firTop (
        .clkDS       (clkDS),
        .rst         (rst),
        .sampleBit   (sampleBit),
        .sampleValid (sampleValid),
        .filterOut   (filterOut),
        .outValid    (outValid)
    );

    always #5 clkDS = ~clkDS;

    // Each tap adds its coefficient for a 1 and subtracts it for a 0
    function automatic sumType ruleSum(windowType win);
        sumType acc;
        int pos;
        acc = '0;
        for (int t = 0; t < tapCount; t++) begin
            pos = (t < lookAhead) ? lookAhead - 1 - t : t;
            if (win[pos]) begin
                acc = acc + sumType'(coefTable[t]);
            end else begin
                acc = acc - sumType'(coefTable[t]);
            end
        end
        return acc;
    endfunction

    task automatic checkSum(input sumType got, input sumType exp, input string what);
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkValid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Outputs are matched in order against the expected queue
    always @(posedge clkDS) begin
        if (!rst && outValid) begin
            if (expQ.size() == 0) begin
                errors++;
                testErrors++;
                $display("[ERROR] %0t: outValid high with no output due", $time);
            end else begin
                checkSum(filterOut, expQ.pop_front(), "filterOut");
            end
        end
    end

    task automatic stepCycle();
        @(posedge clkDS);
        #1;
    endtask

    task automatic resetDut();
        rst = 1'b1;
        sampleBit = 1'b0;
        sampleValid = 1'b0;
        repeat (4) stepCycle();
        rst = 1'b0;
        modelWin = '0;
        modelFill = 0;
        expQ.delete();
    endtask

    task automatic drainQueue();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < drainLimit) begin
            stepCycle();
            n++;
        end
        if (expQ.size() != 0) begin
            errors++;
            testErrors++;
            $display("Timeout: %0d filter outputs never appeared", expQ.size());
            expQ.delete();
        end
    endtask

    task automatic driveSample(input logic b, input logic v, input string expStr);
        sumType s;
        int fileVal;
        sampleBit = b;
        sampleValid = v;
        if (v) begin
            modelWin = {modelWin[tapCount-2:0], b};
            if (modelFill < tapCount) begin
                modelFill++;
            end
        end
        if (v && modelFill == tapCount) begin
            s = ruleSum(modelWin);
            expQ.push_back(s);
            if (expStr != "-") begin
                void'($sscanf(expStr, "%d", fileVal));
                checkSum(s, sumType'(fileVal), "golden value");
            end
        end else if (expStr != "-") begin
            errors++;
            testErrors++;
            $display("Golden file expects an output where the window is not full");
        end
        stepCycle();
        sampleValid = 1'b0;
    endtask

    task automatic finishTest();
        drainQueue();
        checkValid(outValid, 1'b0, "outValid after drain");
        testCount++;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test %s: %s (%0d errors)", testName, (testErrors == 0) ? "ok" : "bad",
                 testErrors);
        testErrors = 0;
    endtask

    initial begin
        string line;
        string expStr;
        int b;
        int v;
        int r;
        int n;
        int gap;
        clkDS = 1'b0;
        rst = 1'b1;
        sampleBit = 1'b0;
        sampleValid = 1'b0;
        seed = 32'h394c_274c;
        errors = 0;
        testErrors = 0;
        testCount = 0;
        failedTests = 0;
        testName = "";
        modelWin = '0;
        modelFill = 0;
        fd = $fopen("sim/fir_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open sim/fir_golden.txt");
        end else begin
            resetDut();
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                if (line.getc(0) == "@") begin
                    if (testName != "") begin
                        finishTest();
                    end
                    void'($sscanf(line, "@%s", testName));
                    continue;
                end
                n = $sscanf(line, "%d %d %d %s", b, v, r, expStr);
                if (n != 4) begin
                    continue;
                end
                if (r != 0) begin
                    drainQueue();
                    resetDut();
                    continue;
                end
                gap = {$random(seed)} % 3;
                repeat (gap) stepCycle();
                driveSample(b[0], v[0], expStr);
            end
            if (testName != "") begin
                finishTest();
            end
            $fclose(fd);
        end
        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Overall limit on simulated time
    initial begin
        #200000;
        $display("Simulation ran past its time limit");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== sim/firTop_props.sv ====
`timescale 1ns/1ps

module firTopProps (
    input logic           clkDS,
    input logic           rst,
    input logic           sampleValid,
    input logic           windowValid,
    input logic           outValid,
    input firPkg::sumType filterOut
);
    import firPkg::*;

    aOutLowAfterReset: assert property (@(posedge clkDS) $past(rst) |-> !outValid)
        else $error("outValid high right after reset");

    // No output without an accepted sample four cycles earlier
    aOutFromSample: assert property (@(posedge clkDS) disable iff (rst)
        outValid |-> $past(sampleValid, 4))
        else $error("outValid without a sample four cycles earlier");

    // Three more stages from window to output
    aOutLatency: assert property (@(posedge clkDS) disable iff (rst)
        outValid == $past(windowValid, 3))
        else $error("outValid not four cycles after a full-window sample");

    aOutKnown: assert property (@(posedge clkDS) disable iff (rst)
        outValid |-> !$isunknown(filterOut))
        else $error("filterOut has unknown bits while valid");

endmodule

bind firTop firTopProps i_firTopProps (
    .clkDS       (clkDS),
    .rst         (rst),
    .sampleValid (sampleValid),
    .windowValid (windowValid),
    .outValid    (outValid),
    .filterOut   (filterOut)
);

// ==== logic/firTop.sv ====
`timescale 1ns/1ps

module firTop (
    input  logic           clkDS,
    input  logic           rst,
    input  logic           sampleBit,
    input  logic           sampleValid,
    output firPkg::sumType filterOut,
    output logic           outValid
);
    import firPkg::*;

    windowType windowBits;
    logic windowValid;
    lutSumType [lutCount-1:0] lutSums;
    logic lutValid;

    sampleWindow i_sampleWindow (
        .clkDS       (clkDS),
        .rst         (rst),
        .sampleBit   (sampleBit),
        .sampleValid (sampleValid),
        .windowBits  (windowBits),
        .windowValid (windowValid)
    );

    // Last slice narrower when taps don't divide evenly
    for (genvar k = 0; k < lutCount; k++) begin : gLut
        localparam int sliceBase = k * lutSize;
        localparam int sliceWidth =
            (tapCount - sliceBase < lutSize) ? tapCount - sliceBase : lutSize;

        coefLut #(
            .lutBase  (sliceBase),
            .lutWidth (sliceWidth)
        ) i_coefLut (
            .clkDS     (clkDS),
            .rst       (rst),
            .sliceBits (windowBits[sliceBase +: sliceWidth]),
            .lutSum    (lutSums[k])
        );
    end

    // Matches the lookup table register stage
    always_ff @(posedge clkDS) begin
        if (rst) begin
            lutValid <= 1'b0;
        end else begin
            lutValid <= windowValid;
        end
    end

    adderTree i_adderTree (
        .clkDS     (clkDS),
        .rst       (rst),
        .leafSums  (lutSums),
        .leafValid (lutValid),
        .treeSum   (filterOut),
        .treeValid (outValid)
    );

endmodule

// ==== logic/adderTree.sv ====
`timescale 1ns/1ps

module adderTree (
    input  logic                                        clkDS,
    input  logic                                        rst,
    input  firPkg::lutSumType [firPkg::lutCount-1:0]    leafSums,
    input  logic                                        leafValid,
    output firPkg::sumType                              treeSum,
    output logic                                        treeValid
);
    import firPkg::*;

    localparam int extBits = $bits(sumType) - $bits(lutSumType);

    // Nodes alive in a given layer, layer 0 being the leaves
    function automatic int nodeCount(int layer);
        int n;
        n = lutCount;
        for (int i = 0; i < layer; i++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    sumType nodeSum [treeLayers+1][lutCount];
    logic [treeLayers-1:0] validPipe;

    for (genvar j = 0; j < lutCount; j++) begin : gLeaf
        assign nodeSum[0][j] = {{extBits{leafSums[j][$bits(lutSumType)-1]}}, leafSums[j]};
    end

    for (genvar l = 1; l <= treeLayers; l++) begin : gLayer
        localparam int prevNodes = nodeCount(l - 1);
        localparam int thisNodes = nodeCount(l);

        for (genvar j = 0; j < lutCount; j++) begin : gNode
            if (j < thisNodes) begin : gLive
                sumType nodeReg;

                always_ff @(posedge clkDS) begin
                    if (rst) begin
                        nodeReg <= '0;
                    end else if (2 * j + 1 < prevNodes) begin
                        nodeReg <= nodeSum[l-1][2*j] + nodeSum[l-1][2*j+1];
                    end else begin
                        // Odd leftover passes through to keep layer timing
                        nodeReg <= nodeSum[l-1][2*j];
                    end
                end

                assign nodeSum[l][j] = nodeReg;
            end else begin : gIdle
                assign nodeSum[l][j] = '0;
            end
        end
    end

    // One valid stage per adder layer
    always_ff @(posedge clkDS) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= leafValid;
            for (int l = 1; l < treeLayers; l++) begin
                validPipe[l] <= validPipe[l-1];
            end
        end
    end

    assign treeSum = nodeSum[treeLayers][0];
    assign treeValid = validPipe[treeLayers-1];

endmodule

// ==== logic/coefLut.sv ====
`timescale 1ns/1ps

module coefLut #(
    parameter int lutBase = 0,
    parameter int lutWidth = firPkg::lutSize
) (
    input  logic                clkDS,
    input  logic                rst,
    input  logic [lutWidth-1:0] sliceBits,
    output firPkg::lutSumType   lutSum
);
    import firPkg::*;

    localparam int entryCount = 2 ** lutWidth;

    // Bipolar sum, a set bit adds its coefficient and a clear bit subtracts it
    function automatic lutSumType entrySum(int sel);
        lutSumType acc;
        acc = '0;
        for (int i = 0; i < lutWidth; i++) begin
            if (sel[i]) begin
                acc = acc + lutSumType'(coefTable[lutBase+i]);
            end else begin
                acc = acc - lutSumType'(coefTable[lutBase+i]);
            end
        end
        return acc;
    endfunction

    lutSumType lutTable [entryCount];

    for (genvar e = 0; e < entryCount; e++) begin : gEntry
        localparam lutSumType entryVal = entrySum(e);
        assign lutTable[e] = entryVal;
    end

    always_ff @(posedge clkDS) begin
        if (rst) begin
            lutSum <= '0;
        end else begin
            lutSum <= lutTable[sliceBits];
        end
    end

endmodule

// ==== logic/sampleWindow.sv ====
`timescale 1ns/1ps

module sampleWindow (
    input  logic              clkDS,
    input  logic              rst,
    input  logic              sampleBit,
    input  logic              sampleValid,
    output firPkg::windowType windowBits,
    output logic              windowValid
);
    import firPkg::*;

    localparam int fillWidth = $clog2(tapCount + 1);
    localparam logic [fillWidth-1:0] fillFull = fillWidth'(tapCount);

    // Position 0 holds the newest sample
    windowType shiftReg;
    logic [fillWidth-1:0] fillCount;

    always_ff @(posedge clkDS) begin
        if (rst) begin
            shiftReg <= '0;
            fillCount <= '0;
            windowValid <= 1'b0;
        end else begin
            windowValid <= 1'b0;
            if (sampleValid) begin
                shiftReg <= {shiftReg[tapCount-2:0], sampleBit};
                if (fillCount != fillFull) begin
                    fillCount <= fillCount + 1'b1;
                end
                // Full once this shift brings in the last missing sample
                windowValid <= (fillCount >= fillFull - 1'b1);
            end
        end
    end

    // Lookahead half reversed into tap order
    for (genvar i = 0; i < lookAhead; i++) begin : gAhead
        assign windowBits[i] = shiftReg[lookAhead-1-i];
    end

    assign windowBits[tapCount-1:lookAhead] = shiftReg[tapCount-1:lookAhead];

endmodule

// ==== logic/firPkg.sv ====
package firPkg;

    // Window geometry
    localparam int lookAhead = 12;
    localparam int lookBack = 12;
    localparam int tapCount = lookAhead + lookBack;

    // Distributed arithmetic partitioning
    localparam int lutSize = 6;
    localparam int lutCount = (tapCount + lutSize - 1) / lutSize;
    localparam int treeLayers = $clog2(lutCount);

    typedef logic signed [15:0] coefType;
    typedef logic signed [18:0] lutSumType;
    typedef logic signed [20:0] sumType;
    typedef logic [tapCount-1:0] windowType;

    // Taps 0..11 lookahead, taps 12..23 lookback
    localparam coefType coefTable [tapCount] = '{
        16'sd18,
        -16'sd41,
        16'sd73,
        -16'sd120,
        16'sd185,
        -16'sd272,
        16'sd390,
        -16'sd561,
        16'sd836,
        -16'sd1382,
        16'sd3120,
        16'sd9860,
        16'sd9860,
        16'sd3120,
        -16'sd1382,
        16'sd836,
        -16'sd561,
        16'sd390,
        -16'sd272,
        16'sd185,
        -16'sd120,
        16'sd73,
        -16'sd41,
        16'sd18
    };

endpackage
